// ==== Bender.yml ====
package:
  name: nts_timestamp

sources:
  # Design, package first
  - files:
      - rtl/nts_pkg.sv
      - rtl/nts_api_regs.sv
      - rtl/nts_ts_capture.sv
      - rtl/nts_header_build.sv
      - rtl/nts_tx_seq.sv
      - rtl/nts_timestamp.sv

  # Simulation only
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_nts_timestamp.sv

// ==== files.f ====
rtl/nts_pkg.sv
rtl/nts_api_regs.sv
rtl/nts_ts_capture.sv
rtl/nts_header_build.sv
rtl/nts_tx_seq.sv
rtl/nts_timestamp.sv
tests/tb_clk_gen.sv
tests/tb_nts_timestamp.sv

// ==== rtl/nts_api_regs.sv ====
// NTS timestamp configuration register bank with API read and write decode
`timescale 1ns/1ns

module nts_api_regs (
  input  logic               i_clk,
  input  logic               i_areset,
  input  nts_pkg::api_req_t  i_api,           // Register port request
  output logic [31:0]        o_api_read_data, // Combinational read data
  output nts_pkg::cfg_regs_t o_cfg            // Server-side configuration
);

  nts_pkg::cfg_regs_t cfg_q;

  logic wr_stb; // Valid write this cycle
  logic rd_stb; // Valid read this cycle

  assign wr_stb = i_api.cs & i_api.we;
  assign rd_stb = i_api.cs & ~i_api.we;

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      cfg_q <= '0;
    end else if (wr_stb) begin
      case (i_api.address)
        nts_pkg::ADDR_NTP_CONFIG: begin
          cfg_q.ntp_config <= nts_pkg::ntp_config_t'(i_api.write_data);
        end
        nts_pkg::ADDR_NTP_ROOT_DELAY: begin
          cfg_q.root_delay <= i_api.write_data;
        end
        nts_pkg::ADDR_NTP_ROOT_DISP: begin
          cfg_q.root_disp <= i_api.write_data;
        end
        nts_pkg::ADDR_NTP_REF_ID: begin
          cfg_q.ref_id <= i_api.write_data;
        end
        nts_pkg::ADDR_NTP_TX_OFS: begin
          cfg_q.tx_ofs <= i_api.write_data;
        end
        default: begin
          // Identity words and unmapped addresses ignore writes
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    o_api_read_data = '0; // Writes and unmapped addresses read 0
    if (rd_stb) begin
      case (i_api.address)
        nts_pkg::ADDR_NAME0:          o_api_read_data = nts_pkg::CORE_NAME0;
        nts_pkg::ADDR_NAME1:          o_api_read_data = nts_pkg::CORE_NAME1;
        nts_pkg::ADDR_VERSION:        o_api_read_data = nts_pkg::CORE_VERSION;
        nts_pkg::ADDR_NTP_CONFIG:     o_api_read_data = cfg_q.ntp_config;
        nts_pkg::ADDR_NTP_ROOT_DELAY: o_api_read_data = cfg_q.root_delay;
        nts_pkg::ADDR_NTP_ROOT_DISP:  o_api_read_data = cfg_q.root_disp;
        nts_pkg::ADDR_NTP_REF_ID:     o_api_read_data = cfg_q.ref_id;
        nts_pkg::ADDR_NTP_TX_OFS:     o_api_read_data = cfg_q.tx_ofs;
        default:                      o_api_read_data = '0;
      endcase
    end
  end

  assign o_cfg = cfg_q;

endmodule

// ==== rtl/nts_header_build.sv ====
// NTS timestamp NTP header assembly with field defaults and 64-bit block select
`timescale 1ns/1ns

module nts_header_build (
  input  nts_pkg::cfg_regs_t  i_cfg,
  input  nts_pkg::capture_t   i_cap,
  input  nts_pkg::block_idx_t i_block, // 0 is the first word on the wire
  output logic [63:0]         o_data
);

  nts_pkg::ntp_config_t                 word0;  // Resolved first word
  logic [31:0]                          ref_id;
  logic [nts_pkg::NTP_HEADER_BITS-1:0]  header;

  // ------------------------------------------------------------
  // Field resolution
  // ------------------------------------------------------------
  always_comb begin
    word0.li        = i_cfg.ntp_config.li;
    word0.precision = i_cfg.ntp_config.precision;
    // Configured value wins when non-zero
    word0.vn   = (i_cfg.ntp_config.vn != '0) ? i_cfg.ntp_config.vn : i_cap.version;
    word0.mode = (i_cfg.ntp_config.mode != '0) ? i_cfg.ntp_config.mode
                                               : nts_pkg::DEFAULT_MODE;
    word0.poll = (i_cfg.ntp_config.poll != '0) ? i_cfg.ntp_config.poll : i_cap.poll;
    if (i_cap.kiss_of_death) begin
      word0.stratum = 8'd0; // KoD packets carry stratum 0
    end else if (i_cfg.ntp_config.stratum != '0) begin
      word0.stratum = i_cfg.ntp_config.stratum;
    end else begin
      word0.stratum = nts_pkg::DEFAULT_STRATUM;
    end
  end

  assign ref_id = i_cap.kiss_of_death ? nts_pkg::NTS_KISS_OF_DEATH : i_cfg.ref_id;

  // RFC 5905 field order, most significant first
  assign header = {word0,
                   i_cfg.root_delay,
                   i_cfg.root_disp,
                   ref_id,
                   i_cap.ref_seconds, 32'h0, // Reference timestamp
                   i_cap.origin,
                   i_cap.receive,
                   i_cap.transmit};

  // ------------------------------------------------------------
  // Block select
  // ------------------------------------------------------------
  always_comb begin
    o_data = '0;
    if (i_block < nts_pkg::NTP_HEADER_BLOCKS) begin
      o_data = header[(nts_pkg::NTP_HEADER_BITS - 1) - 64 * i_block -: 64];
    end
  end

endmodule

// ==== rtl/nts_pkg.sv ====
// NTS timestamp shared constants, register map and packed field groups
package nts_pkg;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------
  localparam logic [7:0] ADDR_NAME0          = 8'h00;
  localparam logic [7:0] ADDR_NAME1          = 8'h01;
  localparam logic [7:0] ADDR_VERSION        = 8'h02;
  localparam logic [7:0] ADDR_NTP_CONFIG     = 8'h0a; // LI VN Mode Stratum Poll Precision
  localparam logic [7:0] ADDR_NTP_ROOT_DELAY = 8'h0b;
  localparam logic [7:0] ADDR_NTP_ROOT_DISP  = 8'h0c;
  localparam logic [7:0] ADDR_NTP_REF_ID     = 8'h0d;
  localparam logic [7:0] ADDR_NTP_TX_OFS     = 8'h0e; // Added to transmit timestamp

  // Read-only identity words
  localparam logic [31:0] CORE_NAME0   = 32'h74696d65; // "time"
  localparam logic [31:0] CORE_NAME1   = 32'h73746d70; // "stmp"
  localparam logic [31:0] CORE_VERSION = 32'h302e3032; // "0.02"

  // ------------------------------------------------------------
  // NTP header constants
  // ------------------------------------------------------------
  localparam int NTP_HEADER_BITS   = 384;
  localparam int NTP_HEADER_BLOCKS = NTP_HEADER_BITS / 64; // 6 blocks of 64 bits

  localparam logic [31:0] NTS_KISS_OF_DEATH = 32'h4e54534e; // "NTSN"
  localparam logic [2:0]  DEFAULT_MODE      = 3'd4;         // Server
  localparam logic [7:0]  DEFAULT_STRATUM   = 8'd1;         // Primary reference

  // ------------------------------------------------------------
  // Field groups
  // ------------------------------------------------------------
  typedef struct packed {
    logic [31:0] seconds;  // Since NTP era start
    logic [31:0] fraction;
  } ntp_ts_t;

  typedef logic [2:0] block_idx_t; // Header block 0..5

  // First header word, field order as on the wire
  typedef struct packed {
    logic [1:0] li;
    logic [2:0] vn;
    logic [2:0] mode;
    logic [7:0] stratum;
    logic [7:0] poll;
    logic [7:0] precision;
  } ntp_config_t;

  typedef struct packed {
    ntp_config_t ntp_config;
    logic [31:0] root_delay;
    logic [31:0] root_disp;
    logic [31:0] ref_id;
    logic [31:0] tx_ofs;
  } cfg_regs_t;

  typedef struct packed {
    logic        cs;
    logic        we;
    logic [7:0]  address;
    logic [31:0] write_data;
  } api_req_t;

  // Client fields from the packet parser
  typedef struct packed {
    ntp_ts_t    origin;
    logic [2:0] version;
    logic [7:0] poll;
    logic       kiss_of_death;
  } parser_req_t;

  typedef struct packed {
    ntp_ts_t     origin;
    ntp_ts_t     receive;
    ntp_ts_t     transmit;
    logic [31:0] ref_seconds;  // Reference time, fraction is always 0
    logic [2:0]  version;
    logic [7:0]  poll;
    logic        kiss_of_death;
  } capture_t;

endpackage

// ==== rtl/nts_timestamp.sv ====
// NTS timestamp top level building the NTP response header from config and parser
`timescale 1ns/1ns

module nts_timestamp (
  input  logic                 i_clk,
  input  logic                 i_areset,
  // NTP time source
  input  nts_pkg::ntp_ts_t     i_ntp_time,
  // Parser side
  input  logic                 i_parser_clear,
  input  logic                 i_parser_record_receive_timestamp,
  input  logic                 i_parser_transmit,
  input  nts_pkg::parser_req_t i_parser,
  output logic                 o_busy,
  // Header output
  output logic                 o_tx_wr_en,
  output nts_pkg::block_idx_t  o_tx_ntp_header_block,
  output logic [63:0]          o_tx_ntp_header_data,
  // Register port
  input  nts_pkg::api_req_t    i_api,
  output logic [31:0]          o_api_read_data
);

  nts_pkg::cfg_regs_t  cfg;
  nts_pkg::capture_t   cap;
  nts_pkg::block_idx_t block;
  logic                capture_rx;
  logic                capture_tx;

  nts_api_regs api_regs_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_api           (i_api),
    .o_api_read_data (o_api_read_data),
    .o_cfg           (cfg)
  );

  nts_tx_seq tx_seq_i (
    .i_clk                             (i_clk),
    .i_areset                          (i_areset),
    .i_parser_clear                    (i_parser_clear),
    .i_parser_record_receive_timestamp (i_parser_record_receive_timestamp),
    .i_parser_transmit                 (i_parser_transmit),
    .o_capture_rx                      (capture_rx),
    .o_capture_tx                      (capture_tx),
    .o_busy                            (o_busy),
    .o_tx_wr_en                        (o_tx_wr_en),
    .o_block                           (block)
  );

  nts_ts_capture ts_capture_i (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_capture_rx (capture_rx),
    .i_capture_tx (capture_tx),
    .i_ntp_time   (i_ntp_time),
    .i_parser     (i_parser),
    .i_tx_ofs     (cfg.tx_ofs),
    .o_cap        (cap)
  );

  // Header follows live config registers during transmission
  nts_header_build header_build_i (
    .i_cfg   (cfg),
    .i_cap   (cap),
    .i_block (block),
    .o_data  (o_tx_ntp_header_data)
  );

  assign o_tx_ntp_header_block = block;

endmodule

// ==== rtl/nts_ts_capture.sv ====
// NTS timestamp capture of receive, origin and transmit times and client fields
`timescale 1ns/1ns

module nts_ts_capture (
  input  logic                 i_clk,
  input  logic                 i_areset,
  input  logic                 i_capture_rx, // Latch receive timestamp
  input  logic                 i_capture_tx, // Latch transmit side fields
  input  nts_pkg::ntp_ts_t     i_ntp_time,   // Free-running NTP time
  input  nts_pkg::parser_req_t i_parser,
  input  logic [31:0]          i_tx_ofs,     // Transmit offset from config
  output nts_pkg::capture_t    o_cap
);

  nts_pkg::capture_t cap_q;
  nts_pkg::ntp_ts_t  tx_time;   // Time plus offset
  logic [31:0]       ref_secs;

  // Offset only reaches the fraction and carries into seconds
  assign tx_time  = nts_pkg::ntp_ts_t'(i_ntp_time + {32'h0, i_tx_ofs});
  // Reference assumed set on the previous PPS
  assign ref_secs = i_ntp_time.seconds - 32'd1;

  // ------------------------------------------------------------
  // Capture registers
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      cap_q <= '0;
    end else begin
      if (i_capture_rx) begin
        cap_q.receive <= i_ntp_time;
      end
      if (i_capture_tx) begin
        cap_q.origin        <= i_parser.origin;       // Echo client transmit time
        cap_q.transmit      <= tx_time;
        cap_q.ref_seconds   <= ref_secs;
        cap_q.version       <= i_parser.version;
        cap_q.poll          <= i_parser.poll;
        cap_q.kiss_of_death <= i_parser.kiss_of_death; // Frozen for the whole header
      end
    end
  end

  assign o_cap = cap_q;

  // Both strobes may load together, an unknown strobe would corrupt the header
  a_strobes_known: assert property (
    @(posedge i_clk) disable iff (i_areset)
    !$isunknown({i_capture_rx, i_capture_tx})
  );

endmodule

// ==== rtl/nts_tx_seq.sv ====
// NTS timestamp transmit sequencer gating parser strobes and stepping header blocks
`timescale 1ns/1ns

module nts_tx_seq (
  input  logic                i_clk,
  input  logic                i_areset,
  input  logic                i_parser_clear,    // Abort current packet
  input  logic                i_parser_record_receive_timestamp,
  input  logic                i_parser_transmit, // Packet ready to answer
  output logic                o_capture_rx,
  output logic                o_capture_tx,
  output logic                o_busy,
  output logic                o_tx_wr_en,
  output nts_pkg::block_idx_t o_block
);

  typedef enum logic {
    ST_IDLE,
    ST_TX
  } state_t;

  localparam nts_pkg::block_idx_t LAST_BLOCK =
    nts_pkg::block_idx_t'(nts_pkg::NTP_HEADER_BLOCKS - 1);

  state_t              state_q;
  nts_pkg::block_idx_t block_q;
  logic                idle;

  assign idle = (state_q == ST_IDLE);

  // Strobes only honoured between packets, clear overrides both
  assign o_capture_rx = idle & ~i_parser_clear & i_parser_record_receive_timestamp;
  assign o_capture_tx = idle & ~i_parser_clear & i_parser_transmit;

  // ------------------------------------------------------------
  // State and block counter
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= ST_IDLE;
      block_q <= '0;
    end else if (i_parser_clear) begin
      state_q <= ST_IDLE; // Drop partial header
      block_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_parser_transmit) begin
            state_q <= ST_TX; // Block 0 goes out next cycle
          end
        end
        ST_TX: begin
          if (block_q == LAST_BLOCK) begin
            state_q <= ST_IDLE;
            block_q <= '0;
          end else begin
            block_q <= block_q + 3'd1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
          block_q <= '0;
        end
      endcase
    end
  end

  assign o_busy     = ~idle;
  assign o_tx_wr_en = (state_q == ST_TX); // One block per cycle, no back-pressure
  assign o_block    = block_q;

  a_block_range: assert property (
    @(posedge i_clk) disable iff (i_areset)
    o_tx_wr_en |-> (block_q < nts_pkg::NTP_HEADER_BLOCKS)
  );

  a_idle_index: assert property (
    @(posedge i_clk) disable iff (i_areset)
    idle |-> (block_q == '0)
  );

endmodule

// ==== tests/tb_clk_gen.sv ====
// Testbench clock source, 100 ns period, with reset held for the first three cycles
`timescale 1ns/1ns

module tb_clk_gen (
  output logic o_clk,
  output logic o_areset
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk; // 100 ns period
  end

  initial begin
    o_areset = 1'b1;
    repeat (3) @(posedge o_clk);
    #10 o_areset = 1'b0; // Released off the edge like other inputs
  end

endmodule

// ==== tests/tb_nts_timestamp.sv ====
// Testbench for the NTS timestamp header builder with reference model and block checker
`timescale 1ns/1ns

module tb_nts_timestamp;

  localparam int DRIVE_DLY = 10; // Input change after rising edge

  // Test lengths in cycles
  localparam int LEN_RESET     = 4;
  localparam int LEN_REGS      = 16;
  localparam int LEN_DEFAULTS  = 10;
  localparam int LEN_OVERRIDES = 16;
  localparam int LEN_KOD       = 12;
  localparam int LEN_TIMING    = 12;
  localparam int LEN_CLEAR     = 14;
  localparam int TIMEOUT_CYCLES = 2 * (LEN_RESET + LEN_REGS + LEN_DEFAULTS + LEN_OVERRIDES
                                       + LEN_KOD + LEN_TIMING + LEN_CLEAR);

  localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

  logic                 clk;
  logic                 areset;
  nts_pkg::ntp_ts_t     ntp_time;
  logic                 parser_clear;
  logic                 parser_rx;
  logic                 parser_tx;
  nts_pkg::parser_req_t parser;
  nts_pkg::api_req_t    api;
  logic                 busy;
  logic                 tx_wr_en;
  nts_pkg::block_idx_t  tx_block;
  logic [63:0]          tx_data;
  logic [31:0]          api_rdata;

  // Reference state
  nts_pkg::cfg_regs_t model_cfg;
  nts_pkg::capture_t  model_cap;
  logic [63:0]        hdr [0:5];     // Last collected header
  logic [31:0]        lfsr_state;
  string              test_name;
  int                 cycle_count = 0;
  int                 exp_idx = 0;

  tb_clk_gen clk_gen_i (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_timestamp nts_timestamp_i (
    .i_clk                             (clk),
    .i_areset                          (areset),
    .i_ntp_time                        (ntp_time),
    .i_parser_clear                    (parser_clear),
    .i_parser_record_receive_timestamp (parser_rx),
    .i_parser_transmit                 (parser_tx),
    .i_parser                          (parser),
    .o_busy                            (busy),
    .o_tx_wr_en                        (tx_wr_en),
    .o_tx_ntp_header_block             (tx_block),
    .o_tx_ntp_header_data              (tx_data),
    .i_api                             (api),
    .o_api_read_data                   (api_rdata)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic check_equal(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error: test %s, %s: expected 0x%h, actual 0x%h",
               test_name, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS; // Feedback on shifted-out bit
    end
    return next;
  endfunction

  // One LFSR step per bit
  task automatic random_bits(input int nbits, output logic [63:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[62:0], lfsr_state[0]};
    end
  endtask

  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Expected header block from the NTP field rules
  function automatic logic [63:0] expected_block(input nts_pkg::cfg_regs_t cfg,
                                                 input nts_pkg::capture_t cap, input int idx);
    logic [2:0]  vn;
    logic [2:0]  mode;
    logic [7:0]  stratum;
    logic [7:0]  poll;
    logic [31:0] word0;
    logic [31:0] ref_id;
    logic [63:0] block;
    vn   = (cfg.ntp_config.vn != 3'd0) ? cfg.ntp_config.vn : cap.version;
    mode = (cfg.ntp_config.mode != 3'd0) ? cfg.ntp_config.mode : 3'd4; // Server
    poll = (cfg.ntp_config.poll != 8'd0) ? cfg.ntp_config.poll : cap.poll;
    if (cap.kiss_of_death) begin
      stratum = 8'd0;
    end else if (cfg.ntp_config.stratum != 8'd0) begin
      stratum = cfg.ntp_config.stratum;
    end else begin
      stratum = 8'd1;
    end
    ref_id = cap.kiss_of_death ? "NTSN" : cfg.ref_id;
    word0  = {cfg.ntp_config.li, vn, mode, stratum, poll, cfg.ntp_config.precision};
    case (idx)
      0:       block = {word0, cfg.root_delay};
      1:       block = {cfg.root_disp, ref_id};
      2:       block = {cap.ref_seconds, 32'h0}; // Reference timestamp
      3:       block = cap.origin;
      4:       block = cap.receive;
      5:       block = cap.transmit;
      default: block = '0;
    endcase
    return block;
  endfunction

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    api.cs         = 1'b1;
    api.we         = 1'b1;
    api.address    = addr;
    api.write_data = data;
    step();
    api = '0;
    case (addr)
      nts_pkg::ADDR_NTP_CONFIG:     model_cfg.ntp_config = nts_pkg::ntp_config_t'(data);
      nts_pkg::ADDR_NTP_ROOT_DELAY: model_cfg.root_delay = data;
      nts_pkg::ADDR_NTP_ROOT_DISP:  model_cfg.root_disp  = data;
      nts_pkg::ADDR_NTP_REF_ID:     model_cfg.ref_id     = data;
      nts_pkg::ADDR_NTP_TX_OFS:     model_cfg.tx_ofs     = data;
      default: begin
        // Read-only or unmapped
      end
    endcase
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    api.cs         = 1'b1;
    api.we         = 1'b0;
    api.address    = addr;
    api.write_data = 32'h0;
    @(negedge clk); // Combinational read, settled mid-cycle
    data = api_rdata;
    step();
    api = '0;
  endtask

  task automatic write_read_back(input logic [7:0] addr, input string what);
    logic [63:0] rnd;
    logic [31:0] rdata;
    random_bits(32, rnd);
    reg_write(addr, rnd[31:0]);
    reg_read(addr, rdata);
    check_equal(what, rnd[31:0], rdata);
  endtask

  // Fresh time and client fields, KoD off
  task automatic randomize_inputs();
    logic [63:0] rnd;
    random_bits(64, rnd);
    ntp_time = nts_pkg::ntp_ts_t'(rnd);
    random_bits(64, rnd);
    parser.origin = nts_pkg::ntp_ts_t'(rnd);
    random_bits(3, rnd);
    parser.version = rnd[2:0];
    random_bits(8, rnd);
    parser.poll = rnd[7:0];
    parser.kiss_of_death = 1'b0;
  endtask

  task automatic record_receive();
    parser_rx = 1'b1;
    step();
    parser_rx = 1'b0;
    model_cap.receive = ntp_time;
  endtask

  task automatic start_transmit();
    parser_tx = 1'b1;
    step();
    parser_tx = 1'b0;
    model_cap.origin        = parser.origin;
    model_cap.transmit      = nts_pkg::ntp_ts_t'(ntp_time + {32'h0, model_cfg.tx_ofs});
    model_cap.ref_seconds   = ntp_time.seconds - 32'd1;
    model_cap.version       = parser.version;
    model_cap.poll          = parser.poll;
    model_cap.kiss_of_death = parser.kiss_of_death;
  endtask

  // Gather blocks until busy drops
  task automatic collect_header(output int nblocks);
    nblocks = 0;
    @(negedge clk);
    while (busy) begin
      check_equal("write enable follows busy", busy, tx_wr_en);
      if (nblocks < 6) begin
        hdr[nblocks] = tx_data;
      end
      nblocks++;
      @(negedge clk);
    end
    step();
  endtask

  task automatic transmit_and_collect(output int nblocks);
    start_transmit();
    collect_header(nblocks);
  endtask

  // ------------------------------------------------------------
  // Block checker and timeout
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (areset || !tx_wr_en) begin
      exp_idx = 0; // Next header starts at block 0
    end else begin
      check_equal("block index", exp_idx, tx_block);
      check_equal($sformatf("block %0d", exp_idx),
                  expected_block(model_cfg, model_cap, exp_idx), tx_data);
      exp_idx = (exp_idx == 5) ? 0 : exp_idx + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Run stopped by timeout");
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [63:0]      rnd;
    logic [31:0]      rdata;
    logic [31:0]      cfg_word;
    logic [63:0]      exp_tx;
    nts_pkg::ntp_ts_t rx_time;
    int               nblocks;
    int               busy_cycles;
    ntp_time     = '0;
    parser_clear = 1'b0;
    parser_rx    = 1'b0;
    parser_tx    = 1'b0;
    parser       = '0;
    api          = '0;
    model_cfg    = '0;
    model_cap    = '0;
    lfsr_state   = 32'd94619;
    test_name    = "reset";
    wait (!areset);
    step();

    test_name = "register access";
    reg_read(nts_pkg::ADDR_NAME0, rdata);
    check_equal("name0", "time", rdata);
    reg_read(nts_pkg::ADDR_NAME1, rdata);
    check_equal("name1", "stmp", rdata);
    reg_read(nts_pkg::ADDR_VERSION, rdata);
    check_equal("version", "0.02", rdata);
    write_read_back(nts_pkg::ADDR_NTP_CONFIG, "config");
    write_read_back(nts_pkg::ADDR_NTP_ROOT_DELAY, "root delay");
    write_read_back(nts_pkg::ADDR_NTP_ROOT_DISP, "root dispersion");
    write_read_back(nts_pkg::ADDR_NTP_REF_ID, "reference id");
    write_read_back(nts_pkg::ADDR_NTP_TX_OFS, "transmit offset");
    reg_read(8'h05, rdata);
    check_equal("unmapped address", 0, rdata);

    test_name = "defaults";
    reg_write(nts_pkg::ADDR_NTP_CONFIG, 32'h0);
    randomize_inputs();
    transmit_and_collect(nblocks);
    check_equal("header blocks", 6, nblocks);
    check_equal("vn from client", parser.version, hdr[0][61:59]);
    check_equal("default mode", 4, hdr[0][58:56]);
    check_equal("default stratum", 1, hdr[0][55:48]);
    check_equal("poll from client", parser.poll, hdr[0][47:40]);
    check_equal("reference timestamp", {ntp_time.seconds - 32'd1, 32'h0}, hdr[2]);

    test_name = "overrides and timestamps";
    random_bits(32, rnd);
    cfg_word = rnd[31:0] | 32'h09010100; // VN, mode, stratum and poll non-zero
    reg_write(nts_pkg::ADDR_NTP_CONFIG, cfg_word);
    write_read_back(nts_pkg::ADDR_NTP_ROOT_DELAY, "root delay");
    write_read_back(nts_pkg::ADDR_NTP_REF_ID, "reference id");
    write_read_back(nts_pkg::ADDR_NTP_TX_OFS, "transmit offset");
    randomize_inputs();
    record_receive();
    rx_time = ntp_time;
    randomize_inputs();
    exp_tx = ntp_time + {32'h0, model_cfg.tx_ofs};
    transmit_and_collect(nblocks);
    check_equal("header blocks", 6, nblocks);
    check_equal("configured vn", cfg_word[29:27], hdr[0][61:59]);
    check_equal("configured mode", cfg_word[26:24], hdr[0][58:56]);
    check_equal("configured stratum", cfg_word[23:16], hdr[0][55:48]);
    check_equal("configured poll", cfg_word[15:8], hdr[0][47:40]);
    check_equal("receive timestamp", rx_time, hdr[4]);
    check_equal("transmit timestamp", exp_tx, hdr[5]);

    test_name = "kiss of death";
    random_bits(32, rnd);
    reg_write(nts_pkg::ADDR_NTP_CONFIG, rnd[31:0] | 32'h00010000);
    randomize_inputs();
    parser.kiss_of_death = 1'b1;
    transmit_and_collect(nblocks);
    check_equal("header blocks", 6, nblocks);
    check_equal("kod stratum", 0, hdr[0][55:48]);
    check_equal("kod reference id", "NTSN", hdr[1][31:0]);
    parser.kiss_of_death = 1'b0;

    test_name = "timing and busy";
    randomize_inputs();
    start_transmit();
    busy_cycles = 0;
    for (int c = 0; c < 9; c++) begin
      if (c == 2) begin
        randomize_inputs(); // Strobes land mid-header
        parser_rx = 1'b1;
        parser_tx = 1'b1;
      end else begin
        parser_rx = 1'b0;
        parser_tx = 1'b0;
      end
      @(negedge clk);
      if (busy) begin
        busy_cycles++;
      end
      check_equal("write enable follows busy", busy, tx_wr_en);
      step();
    end
    check_equal("busy cycles", 6, busy_cycles);

    test_name = "clear";
    randomize_inputs();
    start_transmit();
    step();
    parser_clear = 1'b1;
    parser_tx    = 1'b1;
    @(negedge clk);
    check_equal("busy before clear edge", 1, busy);
    step();
    @(negedge clk);
    check_equal("busy after clear", 0, busy);
    check_equal("write enable after clear", 0, tx_wr_en);
    step(); // Idle now, clear still beats transmit
    parser_clear = 1'b0;
    parser_tx    = 1'b0;
    @(negedge clk);
    check_equal("idle after clear", 0, busy);
    step();
    randomize_inputs();
    transmit_and_collect(nblocks);
    check_equal("header blocks after clear", 6, nblocks);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
